/* flist.f */
source/rvIsaPkg.sv
source/hartCfgPkg.sv
source/hartBus.sv
source/fetchUnit.sv
source/intExecUnit.sv
source/retireUnit.sv
source/hartTop.sv
verification/clockGen.sv
verification/hartTb.sv

/* Makefile */
SIM := obj_dir/VhartTb
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module hartTb -f flist.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/hartTb.sv */
`timescale 1ns/1ps

module hartTb;
  import rvIsaPkg::*;
  import hartCfgPkg::*;

  localparam int MemWords = 256;
  // word index of the closing jal-to-self
  localparam int LoopIdx  = 121;
  localparam addrT LoopPc = addrT'(LoopIdx * 4);

  logic    clk;
  logic    arstN;
  addrT    PCF;
  instrT   InstrF;
  logic    InstrStallF = 1'b0;
  logic    RetireValid;
  addrT    RetirePc;
  regIdxT  RetireRd;
  xlenT    RetireData;
  logic    RetireWrite;
  logic    RetireIllegal;
  instRetT InstRetCount;

  instrT imem [MemWords];
  // reference model state
  addrT  modelPc;
  xlenT  modelRegs [32];
  int    retireSeen;
  int    errCount = 0;
  int    hangCount = 0;
  // model expectation for the instruction at modelPc
  instrT  expWord;
  regIdxT expRd;
  xlenT   srcA;
  xlenT   srcB;
  xlenT   expData;
  addrT   expNext;
  logic   expHasData;
  logic   expWrite;
  logic   expIllegal;

  clockGen clkGen (.clk(clk), .arstN(arstN));

  hartTop hartTop_inst (
    .clk           (clk),
    .arstN         (arstN),
    .PCF           (PCF),
    .InstrF        (InstrF),
    .InstrStallF   (InstrStallF),
    .RetireValid   (RetireValid),
    .RetirePc      (RetirePc),
    .RetireRd      (RetireRd),
    .RetireData    (RetireData),
    .RetireWrite   (RetireWrite),
    .RetireIllegal (RetireIllegal),
    .InstRetCount  (InstRetCount)
  );

  // instruction memory answers in the same cycle
  assign InstrF = imem[PCF[9:2]];

  // memory not ready on about a quarter of the cycles
  always @(posedge clk) begin
    InstrStallF <= ($urandom_range(0, 3) == 0);
  end

  //////////////////////////////
  // instruction encoders
  //////////////////////////////

  // sel 0..4 picks add, sub, xor, or, and
  function automatic instrT regOpWord(int sel, regIdxT rs2, regIdxT rs1, regIdxT rd);
    logic [9:0] f7f3;
    case (sel)
      0: f7f3 = 10'b0000000_000;
      1: f7f3 = 10'b0100000_000;
      2: f7f3 = 10'b0000000_100;
      3: f7f3 = 10'b0000000_110;
      default: f7f3 = 10'b0000000_111;
    endcase
    return {f7f3[9:3], rs2, rs1, f7f3[2:0], rd, 7'b0110011};
  endfunction

  function automatic instrT immOpWord(logic [11:0] imm, regIdxT rs1, logic [2:0] f3,
                                      regIdxT rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instrT branchWord(logic [12:0] off, regIdxT rs2, regIdxT rs1,
                                       logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic instrT jalWord(logic [20:0] off, regIdxT rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  //////////////////////////////
  // ISA reference model
  //////////////////////////////

  always_comb begin
    expWord    = imem[modelPc[9:2]];
    expRd      = expWord[11:7];
    srcA       = modelRegs[expWord[19:15]];
    srcB       = modelRegs[expWord[24:20]];
    expNext    = modelPc + 32'd4;
    expData    = '0;
    expHasData = 1'b0;
    expIllegal = 1'b0;
    case (expWord[6:0])
      7'b0110011: begin
        expHasData = 1'b1;
        case ({expWord[31:25], expWord[14:12]})
          10'b0000000_000: expData = srcA + srcB;
          10'b0100000_000: expData = srcA - srcB;
          10'b0000000_100: expData = srcA ^ srcB;
          10'b0000000_110: expData = srcA | srcB;
          10'b0000000_111: expData = srcA & srcB;
          default: begin
            expHasData = 1'b0;
            expIllegal = 1'b1;
          end
        endcase
      end
      // addi is the only legal op-imm
      7'b0010011: begin
        expHasData = (expWord[14:12] == 3'b000);
        expIllegal = !expHasData;
        expData    = srcA + {{20{expWord[31]}}, expWord[31:20]};
      end
      7'b0110111: begin
        expHasData = 1'b1;
        expData    = {expWord[31:12], 12'b0};
      end
      7'b1100011: begin
        expIllegal = (expWord[14:13] != 2'b00);
        // beq taken on equal, bne on unequal
        if (!expIllegal && ((srcA == srcB) != expWord[12])) begin
          expNext = modelPc + {{19{expWord[31]}}, expWord[31], expWord[7],
                               expWord[30:25], expWord[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        expHasData = 1'b1;
        expData    = modelPc + 32'd4;
        expNext    = modelPc + {{11{expWord[31]}}, expWord[31], expWord[19:12],
                                expWord[20], expWord[30:21], 1'b0};
      end
      default: expIllegal = 1'b1;
    endcase
    expWrite = expHasData && (expRd != 5'd0);
  end

  // model steps once per retire pulse
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      modelPc    <= ResetVector;
      retireSeen <= 0;
      for (int r = 0; r < 32; r++) begin
        modelRegs[r] <= '0;
      end
    end else if (RetireValid) begin
      modelPc    <= expNext;
      retireSeen <= retireSeen + 1;
      if (expWrite) modelRegs[expRd] <= expData;
    end
  end

  //////////////////////////////
  // trace checks
  //////////////////////////////

  pcOrder: assert property (@(posedge clk) disable iff (!arstN)
    RetireValid |-> RetirePc == modelPc)
    else begin
      errCount++;
      $display("Mismatch at %0t: retired pc %h, model expects %h",
               $time, $sampled(RetirePc), $sampled(modelPc));
    end

  dataMatch: assert property (@(posedge clk) disable iff (!arstN)
    RetireValid && expHasData |-> RetireData == expData && RetireRd == expRd)
    else begin
      errCount++;
      $display("Mismatch at %0t: pc %h wrote x%0d=%h, model expects x%0d=%h", $time,
               $sampled(RetirePc), $sampled(RetireRd), $sampled(RetireData),
               $sampled(expRd), $sampled(expData));
    end

  flagMatch: assert property (@(posedge clk) disable iff (!arstN)
    RetireValid |-> RetireWrite == expWrite && RetireIllegal == expIllegal)
    else begin
      errCount++;
      $display("Mismatch at %0t: pc %h write/illegal %b%b, model expects %b%b", $time,
               $sampled(RetirePc), $sampled(RetireWrite), $sampled(RetireIllegal),
               $sampled(expWrite), $sampled(expIllegal));
    end

  // counter tracks every pulse, illegal ones too
  countMatch: assert property (@(posedge clk) InstRetCount == instRetT'(retireSeen))
    else begin
      errCount++;
      $display("Mismatch at %0t: InstRetCount %0d, pulses seen %0d",
               $time, $sampled(InstRetCount), $sampled(retireSeen));
    end

  // first fetch takes two more cycles to reach writeback
  resetState: assert property (@(posedge clk)
    $rose(arstN) |-> PCF == ResetVector && !RetireValid ##1 !RetireValid)
    else begin
      errCount++;
      $display("Mismatch at %0t: PCF %h or early retire after reset", $time, $sampled(PCF));
    end

  //////////////////////////////
  // program and run control
  //////////////////////////////

  task automatic waitRetire(output bit timedOut);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!RetireValid && cycles < 200);
    timedOut = !RetireValid;
  endtask

  initial begin
    int     kind;
    int     cycles;
    int     loopHits;
    int     retired;
    bit     timedOut;
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    regIdxT lastRd;
    void'($urandom(32'h37d7));
    // opcode zero everywhere else, an illegal word per address
    for (int i = 0; i < MemWords; i++) begin
      imem[i] = instrT'(i) << 7;
    end
    // x1..x31 get known values before any random read
    for (int r = 1; r < 32; r++) begin
      imem[r-1] = immOpWord(12'($urandom), 5'd0, 3'b000, regIdxT'(r), 7'b0010011);
    end
    lastRd = 5'd31;
    for (int i = 31; i < LoopIdx; i++) begin
      rd   = regIdxT'($urandom);
      // half the sources chain on the previous result
      rs1  = ($urandom_range(0, 1) == 1) ? lastRd : regIdxT'($urandom);
      rs2  = ($urandom_range(0, 3) == 0) ? lastRd : regIdxT'($urandom);
      // no forward jump may land past the loop
      kind = (i >= LoopIdx - 3) ? 0 : $urandom_range(0, 9);
      case (kind)
        0, 1, 2, 3: imem[i] = regOpWord($urandom_range(0, 4), rs2, rs1, rd);
        4, 5: imem[i] = immOpWord(12'($urandom), rs1, 3'b000, rd, 7'b0010011);
        6: imem[i] = {20'($urandom), rd, 7'b0110111};
        7: imem[i] = branchWord(($urandom_range(0, 1) == 1) ? 13'd8 : 13'd12,
                                ($urandom_range(0, 1) == 1) ? rs1 : rs2, rs1,
                                ($urandom_range(0, 1) == 1) ? 3'b001 : 3'b000);
        8: imem[i] = jalWord(($urandom_range(0, 1) == 1) ? 21'd8 : 21'd12, rd);
        // slti and a load are outside the subset
        default: imem[i] = immOpWord(12'($urandom), rs1, 3'b010, rd,
                                     ($urandom_range(0, 1) == 1) ? 7'b0010011 : 7'b0000011);
      endcase
      if (kind <= 6 && rd != 5'd0) lastRd = rd;
    end
    imem[LoopIdx] = jalWord(21'd0, 5'd0);

    cycles = 0;
    while (!arstN && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    loopHits = 0;
    retired  = 0;
    timedOut = 1'b0;
    if (!arstN) begin
      hangCount++;
      $display("Reset was never released");
    end else begin
      while (loopHits < 3 && retired < 1000 && !timedOut) begin
        waitRetire(timedOut);
        if (timedOut) begin
          hangCount++;
          $display("Hang: nothing retired for 200 cycles, model pc %h", modelPc);
        end else begin
          retired++;
          if (RetirePc == LoopPc) loopHits++;
        end
      end
      if (!timedOut && loopHits < 3) begin
        errCount++;
        $display("Program never reached its closing loop after %0d retirements", retired);
      end
    end
    // let the checks of the last retirement fire
    @(posedge clk);
    @(negedge clk);
    $display("errors: %0d mismatches, %0d timeouts, %0d retired",
             errCount, hangCount, retired);
    if (errCount == 0 && hangCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic arstN
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reset held over the first three rising edges
  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;
  end

endmodule

/* source/hartTop.sv */
`timescale 1ns/1ps

module hartTop (
  input  logic                clk,
  input  logic                arstN,
  // instruction memory side
  output rvIsaPkg::addrT      PCF,
  input  rvIsaPkg::instrT     InstrF,
  input  logic                InstrStallF,
  // retire trace
  output logic                RetireValid,
  output rvIsaPkg::addrT      RetirePc,
  output rvIsaPkg::regIdxT    RetireRd,
  output rvIsaPkg::xlenT      RetireData,
  output logic                RetireWrite,
  output logic                RetireIllegal,
  output hartCfgPkg::instRetT InstRetCount
);

  //////////////////////////////
  // stage links
  //////////////////////////////

  fetchBus fBus ();
  wbBus    wBus ();

  // fetch stage, PC and squash logic
  fetchUnit fetchInst (
    .clk         (clk),
    .arstN       (arstN),
    .PCF         (PCF),
    .InstrF      (InstrF),
    .InstrStallF (InstrStallF),
    .fb          (fBus.fetchSide)
  );

  // decode, register file, ALU, branch resolution
  intExecUnit execInst (
    .clk   (clk),
    .arstN (arstN),
    .fb    (fBus.execSide),
    .wb    (wBus.execSide)
  );

  // writeback register and trace
  retireUnit retireInst (
    .clk           (clk),
    .arstN         (arstN),
    .wb            (wBus.retireSide),
    .RetireValid   (RetireValid),
    .RetirePc      (RetirePc),
    .RetireRd      (RetireRd),
    .RetireData    (RetireData),
    .RetireWrite   (RetireWrite),
    .RetireIllegal (RetireIllegal),
    .InstRetCount  (InstRetCount)
  );

endmodule

/* source/retireUnit.sv */
`timescale 1ns/1ps

module retireUnit (
  input  logic                clk,
  input  logic                arstN,
  wbBus.retireSide            wb,
  output logic                RetireValid,
  output rvIsaPkg::addrT      RetirePc,
  output rvIsaPkg::regIdxT    RetireRd,
  output rvIsaPkg::xlenT      RetireData,
  output logic                RetireWrite,
  output logic                RetireIllegal,
  output hartCfgPkg::instRetT InstRetCount
);
  import rvIsaPkg::*;

  // trace-only fields of the writeback stage
  addrT pcW;
  logic illegalW;

  //////////////////////////////
  // writeback register
  //////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wb.wValid <= 1'b0;
      wb.wWrite <= 1'b0;
      illegalW  <= 1'b0;
    end else begin
      wb.wValid <= wb.issueValid;
      wb.wWrite <= wb.issueWrite;
      illegalW  <= wb.issueIllegal;
    end
  end

  always_ff @(posedge clk) begin
    wb.wRd   <= wb.issueRd;
    wb.wData <= wb.issueResult;
    pcW      <= wb.issuePc;
  end

  // trace mirrors the register file write port
  assign RetireValid   = wb.wValid;
  assign RetirePc      = pcW;
  assign RetireRd      = wb.wRd;
  assign RetireData    = wb.wData;
  assign RetireWrite   = wb.wWrite;
  assign RetireIllegal = illegalW;

  // illegal retirements count too
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) InstRetCount <= '0;
    else if (wb.wValid) InstRetCount <= InstRetCount + 1'b1;
  end

  // decode must never mark an illegal word as writing
  noIllegalWrite: assert property (@(posedge clk) disable iff (!arstN)
    !(RetireWrite && RetireIllegal))
    else $error("illegal instruction at %h retired with a register write", RetirePc);

endmodule

/* source/intExecUnit.sv */
`timescale 1ns/1ps

module intExecUnit (
  input logic      clk,
  input logic      arstN,
  fetchBus.execSide fb,
  wbBus.execSide    wb
);
  import rvIsaPkg::*;
  import hartCfgPkg::*;

  // instruction fields
  opcodeT opcode;
  funct3T funct3;
  funct7T funct7;
  regIdxT rd;
  regIdxT rs1;
  regIdxT rs2;
  // immediates, all sign extended
  xlenT   immI;
  xlenT   immU;
  xlenT   immB;
  xlenT   immJ;
  // decoded controls
  aluOpT  aluOp;
  logic   useImm;
  xlenT   immSel;
  logic   writesRd;
  logic   isBranch;
  logic   isJal;
  logic   illegal;
  // operands and results
  xlenT   regFile [NumRegs];
  logic   fwdA;
  logic   fwdB;
  xlenT   rs1Val;
  xlenT   rs2Val;
  xlenT   srcB;
  xlenT   aluOut;
  logic   branchTaken;

  //////////////////////////////
  // decode
  //////////////////////////////

  assign opcode = fb.instrE[6:0];
  assign rd     = fb.instrE[11:7];
  assign funct3 = fb.instrE[14:12];
  assign rs1    = fb.instrE[19:15];
  assign rs2    = fb.instrE[24:20];
  assign funct7 = fb.instrE[31:25];

  assign immI = {{20{fb.instrE[31]}}, fb.instrE[31:20]};
  assign immU = {fb.instrE[31:12], 12'b0};
  assign immB = {{19{fb.instrE[31]}}, fb.instrE[31], fb.instrE[7],
                 fb.instrE[30:25], fb.instrE[11:8], 1'b0};
  assign immJ = {{11{fb.instrE[31]}}, fb.instrE[31], fb.instrE[19:12],
                 fb.instrE[20], fb.instrE[30:21], 1'b0};

  // anything not matched below is illegal and writes nothing
  always_comb begin
    aluOp    = AluAdd;
    useImm   = 1'b0;
    immSel   = immI;
    writesRd = 1'b0;
    isBranch = 1'b0;
    isJal    = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      OpReg: begin
        writesRd = 1'b1;
        case ({funct7, funct3})
          {F7Base, F3AddSub}: aluOp = AluAdd;
          {F7Sub, F3AddSub}:  aluOp = AluSub;
          {F7Base, F3Xor}:    aluOp = AluXor;
          {F7Base, F3Or}:     aluOp = AluOr;
          {F7Base, F3And}:    aluOp = AluAnd;
          default: begin
            writesRd = 1'b0;
            illegal  = 1'b1;
          end
        endcase
      end
      // only ADDI from OP-IMM
      OpImm: begin
        useImm   = 1'b1;
        writesRd = (funct3 == F3AddSub);
        illegal  = (funct3 != F3AddSub);
      end
      OpLui: begin
        aluOp    = AluPassB;
        useImm   = 1'b1;
        immSel   = immU;
        writesRd = 1'b1;
      end
      OpBranch: begin
        isBranch = (funct3 == F3Beq) || (funct3 == F3Bne);
        illegal  = !isBranch;
      end
      OpJal: begin
        isJal    = 1'b1;
        writesRd = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  //////////////////////////////
  // register file + forwarding
  //////////////////////////////

  // write port is the writeback register, x0 never written
  always_ff @(posedge clk) begin
    if (wb.wValid && wb.wWrite && wb.wRd != '0) regFile[wb.wRd] <= wb.wData;
  end

  // writeback result bypasses the array write at the end of this cycle
  assign fwdA   = wb.wValid && wb.wWrite && (wb.wRd == rs1);
  assign fwdB   = wb.wValid && wb.wWrite && (wb.wRd == rs2);
  assign rs1Val = (rs1 == '0) ? '0 : (fwdA ? wb.wData : regFile[rs1]);
  assign rs2Val = (rs2 == '0) ? '0 : (fwdB ? wb.wData : regFile[rs2]);

  //////////////////////////////
  // ALU and control transfer
  //////////////////////////////

  assign srcB = useImm ? immSel : rs2Val;

  always_comb begin
    case (aluOp)
      AluAdd:   aluOut = rs1Val + srcB;
      AluSub:   aluOut = rs1Val - srcB;
      AluAnd:   aluOut = rs1Val & srcB;
      AluOr:    aluOut = rs1Val | srcB;
      AluXor:   aluOut = rs1Val ^ srcB;
      AluPassB: aluOut = srcB;
      default:  aluOut = '0;
    endcase
  end

  // BEQ when funct3 is zero, otherwise BNE
  assign branchTaken = isBranch && ((funct3 == F3Beq) == (rs1Val == rs2Val));

  assign fb.redirectE = fb.validE && (isJal || branchTaken);
  assign fb.targetE   = fb.pcE + (isJal ? immJ : immB);

  // issue to writeback, JAL links PC+4
  assign wb.issueValid   = fb.validE;
  assign wb.issuePc      = fb.pcE;
  assign wb.issueRd      = rd;
  assign wb.issueResult  = isJal ? fb.pcE + 32'd4 : aluOut;
  assign wb.issueWrite   = fb.validE && writesRd && (rd != '0);
  assign wb.issueIllegal = fb.validE && illegal;

  // a redirect comes from a real instruction and its successor is squashed
  redirectSquash: assert property (@(posedge clk) disable iff (!arstN)
    fb.redirectE |-> fb.validE ##1 !fb.validE)
    else $error("redirect without valid instruction or no squash bubble");

endmodule

/* source/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
  input  logic            clk,
  input  logic            arstN,
  output rvIsaPkg::addrT  PCF,
  input  rvIsaPkg::instrT InstrF,
  input  logic            InstrStallF,
  fetchBus.fetchSide      fb
);
  import rvIsaPkg::*;
  import hartCfgPkg::*;

  addrT pcPlus4F;
  addrT pcNextF;
  // instruction in fetch moves on to execute this cycle
  logic acceptF;

  //////////////////////////////
  // next PC
  //////////////////////////////

  assign pcPlus4F = PCF + 32'd4;

  // a redirect wins over a stall, the stalled fetch is dropped anyway
  always_comb begin
    if (fb.redirectE) pcNextF = fb.targetE;
    else if (InstrStallF) pcNextF = PCF;
    else pcNextF = pcPlus4F;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) PCF <= ResetVector;
    else PCF <= pcNextF;
  end

  //////////////////////////////
  // fetch-to-execute register
  //////////////////////////////

  // bubble on memory stall, squash the wrong-path word on redirect
  assign acceptF = !InstrStallF && !fb.redirectE;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) fb.validE <= 1'b0;
    else fb.validE <= acceptF;
  end

  // payload only loads with a real instruction
  always_ff @(posedge clk) begin
    if (acceptF) begin
      fb.pcE    <= PCF;
      fb.instrE <= InstrF;
    end
  end

  // targets from execute must keep fetch on a word boundary
  pcAligned: assert property (@(posedge clk) disable iff (!arstN) PCF[1:0] == 2'b00)
    else $error("fetch PC %h not word aligned", PCF);

endmodule

/* source/hartBus.sv */
`timescale 1ns/1ps

//////////////////////////////
// fetch <-> execute
//////////////////////////////

interface fetchBus;
  import rvIsaPkg::*;

  // fetch-to-execute register contents
  logic  validE;
  addrT  pcE;
  instrT instrE;
  // control transfer back from execute, one-cycle pulse
  logic  redirectE;
  addrT  targetE;

  modport fetchSide (output validE, pcE, instrE, input redirectE, targetE);
  modport execSide  (input validE, pcE, instrE, output redirectE, targetE);
endinterface

//////////////////////////////
// execute <-> writeback
//////////////////////////////

interface wbBus;
  import rvIsaPkg::*;

  // result leaving execute this cycle
  logic   issueValid;
  addrT   issuePc;
  regIdxT issueRd;
  xlenT   issueResult;
  logic   issueWrite;
  logic   issueIllegal;
  // writeback register, also the forwarding source
  logic   wValid;
  regIdxT wRd;
  xlenT   wData;
  logic   wWrite;

  modport execSide (
    output issueValid, issuePc, issueRd, issueResult, issueWrite, issueIllegal,
    input  wValid, wRd, wData, wWrite
  );
  modport retireSide (
    input  issueValid, issuePc, issueRd, issueResult, issueWrite, issueIllegal,
    output wValid, wRd, wData, wWrite
  );
endinterface

/* source/hartCfgPkg.sv */
package hartCfgPkg;

  //////////////////////////////
  // hart build choices
  //////////////////////////////

  // first fetch address after reset
  localparam logic [31:0] ResetVector = 32'h0000_0000;

  // integer register file depth, x0 included
  localparam int NumRegs = 32;

  // retired instruction counter, wraps silently
  localparam int InstRetW = 16;

  typedef logic [InstRetW-1:0] instRetT;

endpackage

/* source/rvIsaPkg.sv */
package rvIsaPkg;

  //////////////////////////////
  // architectural word types
  //////////////////////////////

  // register and data word
  typedef logic [31:0] xlenT;
  // byte address, carries the PC
  typedef logic [31:0] addrT;
  typedef logic [31:0] instrT;
  // x0..x31
  typedef logic [4:0]  regIdxT;

  // instruction fields
  typedef logic [6:0]  opcodeT;
  typedef logic [2:0]  funct3T;
  typedef logic [6:0]  funct7T;

  //////////////////////////////
  // opcodes of the subset
  //////////////////////////////

  localparam opcodeT OpReg    = 7'b0110011;
  localparam opcodeT OpImm    = 7'b0010011;
  localparam opcodeT OpLui    = 7'b0110111;
  localparam opcodeT OpBranch = 7'b1100011;
  localparam opcodeT OpJal    = 7'b1101111;

  // funct3 for OP / OP-IMM
  localparam funct3T F3AddSub = 3'b000;
  localparam funct3T F3Xor    = 3'b100;
  localparam funct3T F3Or     = 3'b110;
  localparam funct3T F3And    = 3'b111;
  // funct3 for branches
  localparam funct3T F3Beq    = 3'b000;
  localparam funct3T F3Bne    = 3'b001;
  // funct7 picks add or sub
  localparam funct7T F7Base   = 7'b0000000;
  localparam funct7T F7Sub    = 7'b0100000;

  // passB feeds the U immediate straight through for LUI
  typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluXor, AluPassB} aluOpT;

endpackage
